//--- dv/ntt_properties.sv
// sampled on posedge clk; latency checks apply only while mode is held and no zeroize is near
`timescale 1ns/1ps

module ntt_properties
    import ntt_ops_pkg::*;
(
    input logic  clk,
    input logic  reset_n,
    input logic  zeroize_i,
    input logic  enable_i,
    input mode_t mode_i,
    input logic  ready_i
);

    logic       bf_mode;
    logic       pw_mode;
    // cycles since the last zeroize or mode change
    logic [3:0] quiet;
    // cycles since the last zeroize
    logic [3:0] zcnt;
    // an enable arrived after that zeroize
    logic       en_since;
    mode_t      mode_q;

    assign bf_mode = (mode_i == ct) || (mode_i == gs);
    assign pw_mode = (mode_i == pwm) || (mode_i == pwa) || (mode_i == pws);

    // ------------------------------
    // history counters
    // ------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            quiet    <= '0;
            zcnt     <= 4'd15;
            en_since <= 1'b0;
            mode_q   <= idle;
        end else begin
            mode_q <= mode_i;
            if (zeroize_i || (mode_i != mode_q)) begin
                quiet <= '0;
            end else if (quiet != 4'd15) begin
                quiet <= quiet + 4'd1;
            end
            if (zeroize_i) begin
                zcnt     <= '0;
                en_since <= 1'b0;
            end else begin
                if (zcnt != 4'd15) begin
                    zcnt <= zcnt + 4'd1;
                end
                if (enable_i) begin
                    en_since <= 1'b1;
                end
            end
        end
    end

    a_ready_in_reset: assert property (@(posedge clk) !reset_n |-> !ready_i)
        else $error("ready_o high while reset_n is low");

    // transform items come out eight cycles after their enable
    a_ready_bf: assert property (@(posedge clk) disable iff (!reset_n)
        (bf_mode && quiet >= 4'd8 && mode_i == $past(mode_i)) |-> (ready_i == $past(enable_i, 8)))
        else $error("ready_o does not follow enable by 8 cycles in ct/gs");

    // pointwise items after four
    a_ready_pw: assert property (@(posedge clk) disable iff (!reset_n)
        (pw_mode && quiet >= 4'd4 && mode_i == $past(mode_i)) |-> (ready_i == $past(enable_i, 4)))
        else $error("ready_o does not follow enable by 4 cycles in pointwise mode");

    a_zeroize_kills: assert property (@(posedge clk) disable iff (!reset_n)
        (zcnt < 4'd8 && !en_since) |-> !ready_i)
        else $error("ready_o for an item that zeroize should have cleared");

endmodule

//--- dv/ntt_tb.sv
// reads dv/ntt_trace.txt from the project root; the pipeline is drained before every change of mode
`timescale 1ns/1ps

module ntt_tb
    import ntt_params_pkg::*;
    import ntt_ops_pkg::*;
();

    // ready latency in cycles for each mode class
    localparam int LAT_BF       = 8;
    localparam int LAT_PW       = 4;
    localparam int RESET_CYCLES = 16;

    // one trace line
    typedef struct {
        mode_t       mode;
        logic        acc;
        logic        zap;
        coeff_quad_t u;
        coeff_quad_t v;
        coeff_quad_t w;
        coeff_quad_t e;
    } trace_t;

    // one item in flight
    typedef struct {
        int          due;
        logic        bf;
        coeff_quad_t val;
    } expect_t;

    logic        clk;
    logic        reset_n;
    logic        zeroize_i;
    logic        enable_i;
    logic        accumulate_i;
    mode_t       mode_i;
    coeff_quad_t u_i;
    coeff_quad_t v_i;
    coeff_quad_t w_i;
    coeff_quad_t uv_o;
    coeff_quad_t pwo_o;
    logic        ready_o;

    trace_t      trace_q [$];
    expect_t     exp_q [$];
    int          cyc;
    logic [31:0] rng;
    bit          loaded;
    logic        exp_rdy;

    ntt_top u_dut (
        .clk          (clk),
        .reset_n      (reset_n),
        .zeroize_i    (zeroize_i),
        .enable_i     (enable_i),
        .accumulate_i (accumulate_i),
        .mode_i       (mode_i),
        .u_i          (u_i),
        .v_i          (v_i),
        .w_i          (w_i),
        .uv_o         (uv_o),
        .pwo_o        (pwo_o),
        .ready_o      (ready_o)
    );

    bind ntt_top ntt_properties u_props (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .enable_i  (enable_i),
        .mode_i    (mode_i),
        .ready_i   (ready_o)
    );

    always #5 clk = ~clk;

    // edge count that the driver reads before it updates
    always @(posedge clk) cyc <= cyc + 1;

    function automatic logic [31:0] xorshift(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // ------------------------------
    // compare tasks
    // ------------------------------
    task automatic check_coeff_quad(string name, coeff_quad_t exp, coeff_quad_t act);
        if (act !== exp) begin
            $display("[ERROR] %0t %s expected %h actual %h", $time, name, exp, act);
            $display("CHECKS FAILED");
            $fatal(1, "coefficient mismatch");
        end
    endtask

    task automatic check_ready(logic exp, logic act);
        if (act !== exp) begin
            $display("[ERROR] %0t ready_o expected %b actual %b", $time, exp, act);
            $display("CHECKS FAILED");
            $fatal(1, "handshake mismatch");
        end
    endtask

    task automatic load_trace();
        int          fd;
        int          n;
        int          m;
        int          a;
        int          z;
        string       line;
        logic [31:0] f [16];
        trace_t      t;
        fd = $fopen("dv/ntt_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open the trace file dv/ntt_trace.txt");
            $display("CHECKS FAILED");
            $fatal(1, "no trace");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            // blank lines and column notes
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            n = $sscanf(line, "%d %d %d %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        m, a, z, f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                        f[8], f[9], f[10], f[11], f[12], f[13], f[14], f[15]);
            if (n != 19) begin
                $display("a trace line has %0d fields instead of 19: %s", n, line);
                $display("CHECKS FAILED");
                $fatal(1, "bad trace");
            end
            t.mode = mode_t'(m[2:0]);
            t.acc  = a[0];
            t.zap  = z[0];
            for (int i = 0; i < 4; i++) begin
                t.u[i] = coeff_t'(f[i]);
                t.v[i] = coeff_t'(f[4+i]);
                t.w[i] = coeff_t'(f[8+i]);
                t.e[i] = coeff_t'(f[12+i]);
            end
            trace_q.push_back(t);
        end
        $fclose(fd);
    endtask

    // ------------------------------
    // driver
    // ------------------------------
    task automatic drive_idle();
        @(posedge clk);
        enable_i  <= 1'b0;
        zeroize_i <= 1'b0;
    endtask

    task automatic drive_item(trace_t t, bit push);
        expect_t x;
        @(posedge clk);
        enable_i     <= 1'b1;
        zeroize_i    <= 1'b0;
        accumulate_i <= t.acc;
        mode_i       <= t.mode;
        u_i          <= t.u;
        v_i          <= t.v;
        w_i          <= t.w;
        if (push) begin
            // ct and gs run through both stages
            x.bf  = (t.mode == ct) || (t.mode == gs);
            x.due = cyc + 1 + (x.bf ? LAT_BF : LAT_PW);
            x.val = t.e;
            exp_q.push_back(x);
        end
    endtask

    // wait out every item, then let the enable line empty past tap 8
    task automatic drain();
        while (exp_q.size() != 0) begin
            drive_idle();
        end
        repeat (LAT_BF) drive_idle();
    endtask

    // two items enter, then zeroize kills them before any tap
    task automatic flush_with_zeroize(trace_t t);
        drain();
        drive_item(t, 1'b0);
        drive_item(t, 1'b0);
        @(posedge clk);
        enable_i  <= 1'b0;
        zeroize_i <= 1'b1;
        drive_idle();
    endtask

    // ------------------------------
    // output monitor
    // ------------------------------
    // sampled mid-cycle so both outputs and queue are settled
    always @(negedge clk) begin
        exp_rdy = (exp_q.size() > 0) && (exp_q[0].due == cyc);
        check_ready(exp_rdy, ready_o);
        if (exp_rdy) begin
            if (exp_q[0].bf) begin
                check_coeff_quad("uv_o", exp_q[0].val, uv_o);
            end else begin
                check_coeff_quad("pwo_o", exp_q[0].val, pwo_o);
            end
            void'(exp_q.pop_front());
        end
    end

    initial begin
        wait (loaded);
        #((trace_q.size() * 12 + 200) * 10);
        $display("timeout: the trace did not finish within the allowed time");
        $display("CHECKS FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        trace_t t;
        mode_t  run_mode;
        clk          = 1'b0;
        reset_n      = 1'b0;
        zeroize_i    = 1'b0;
        // a live ct stream while reset is held must still leave ready_o low
        enable_i     = 1'b1;
        accumulate_i = 1'b0;
        mode_i       = ct;
        u_i          = '0;
        v_i          = '0;
        w_i          = '0;
        cyc          = 0;
        rng          = 32'h1638dec3;
        run_mode     = idle;
        load_trace();
        loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset_n  <= 1'b1;
        enable_i <= 1'b0;
        mode_i   <= idle;
        foreach (trace_q[i]) begin
            t = trace_q[i];
            if (t.zap) begin
                flush_with_zeroize(t);
            end else begin
                if (t.mode != run_mode) begin
                    drain();
                end
                drive_item(t, 1'b1);
                // 0 to 3 idle cycles between items
                rng = xorshift(rng);
                repeat (rng[1:0]) drive_idle();
            end
            run_mode = t.mode;
        end
        drain();
        if (exp_q.size() != 0) begin
            $display("%0d expected items never came out", exp_q.size());
            $display("CHECKS FAILED");
            $fatal(1, "items lost");
        end else begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
    end

endmodule

//--- dv/ntt_trace.txt
# mode(0 ct,1 gs,2 pwm,3 pwa,4 pws) acc zap, then hex u0-u3 v0-v3 w0-w3 expected0-3
# zap 1 enables the line twice and clears it by zeroize, so its expected columns are unused
0 0 0 1 2 77 77 3 4 77 77 1 1 1 1 A 7FDFFF 7FDFFD 0
0 0 0 A 14 77 77 1 2 77 77 2 3 5 7 8E 7FDF8B 6A 7FDFA7
0 0 0 0 100 77 77 400000 1 77 77 400000 7FE000 1 2 6018FE 601700 1FCA04 1FC600
0 0 0 A 14 77 77 1 2 77 77 2 3 5 7 8E 7FDF8B 6A 7FDFA7
0 0 0 1 2 77 77 3 4 77 77 1 1 1 1 A 7FDFFF 7FDFFD 0
0 0 1 A 14 77 77 1 2 77 77 2 3 5 7 8E 7FDF8B 6A 7FDFA7
0 0 0 0 100 77 77 400000 1 77 77 400000 7FE000 1 2 6018FE 601700 1FCA04 1FC600
1 0 0 5 9 77 77 3 4 77 77 1 1 1 1 15 7FDFFC 7 7FDFFE
1 0 0 1000 7FE000 77 77 0 1 77 77 800 3 2 7FE000 1000 2000 1FF9 7FBFFC
1 0 0 5 9 77 77 3 4 77 77 1 1 1 1 15 7FDFFC 7 7FDFFE
1 0 0 1000 7FE000 77 77 0 1 77 77 800 3 2 7FE000 1000 2000 1FF9 7FBFFC
2 0 0 7FE000 7FE000 1000 3 7FE000 2 800 7 9 9 9 9 1 7FDFFF 1FFF 15
2 1 0 7FE000 7FE000 1000 3 7FE000 2 800 7 7FE000 5 1 100 0 3 2000 115
2 0 0 400000 7FE000 3E8 0 400000 123456 3E8 7FE000 1 1 1 1 6017FF 6DABAB F4240 0
2 1 0 7FE000 7FE000 1000 3 7FE000 2 800 7 7FE000 5 1 100 0 3 2000 115
2 0 0 7FE000 7FE000 1000 3 7FE000 2 800 7 9 9 9 9 1 7FDFFF 1FFF 15
3 0 0 1 7FE000 400000 7FE000 2 1 3FE002 7FE000 0 0 0 0 3 0 1 7FDFFF
4 0 0 5 0 3 7FE000 3 1 7FE000 1 0 0 0 0 2 7FE000 4 7FDFFF
4 0 0 5 0 3 7FE000 3 1 7FE000 1 0 0 0 0 2 7FE000 4 7FDFFF
4 0 1 5 0 3 7FE000 3 1 7FE000 1 0 0 0 0 2 7FE000 4 7FDFFF
4 0 0 5 0 3 7FE000 3 1 7FE000 1 0 0 0 0 2 7FE000 4 7FDFFF
3 0 0 1 7FE000 400000 7FE000 2 1 3FE002 7FE000 0 0 0 0 3 0 1 7FDFFF

//--- filelist.f
+incdir+include
hw/ntt_params_pkg.sv
hw/ntt_ops_pkg.sv
hw/ntt_ctrl_if.sv
hw/ntt_mod_mult.sv
hw/ntt_butterfly.sv
hw/ntt_butterfly_2x2.sv
hw/ntt_ready_ctrl.sv
hw/ntt_top.sv
dv/ntt_properties.sv
dv/ntt_tb.sv

//--- hw/ntt_butterfly.sv
// inputs below q, four-cycle latency in every mode; mode must not change while items are in flight
`timescale 1ns/1ps
`include "ntt_settings.svh"

module ntt_butterfly
    import ntt_params_pkg::*;
    import ntt_ops_pkg::*;
(
    input  logic   clk,
    input  logic   reset_n,
    ntt_ctrl_if.dp_mp ctrl,
    input  coeff_t u_i,
    input  coeff_t v_i,
    input  coeff_t w_i,
    output coeff_t u_o,
    output coeff_t v_o,
    output coeff_t pw_o
);

    localparam int MD = `NTT_MULT_LATENCY;

    logic   gs_mode;
    logic   pwm_mode;
    logic   pws_mode;
    coeff_t sum_q1;
    coeff_t diff_q1;
    coeff_t w_q1;
    coeff_t mul_a;
    coeff_t mul_b;
    coeff_t prod;
    coeff_t addend;
    coeff_t add_dly [MD];
    coeff_t as_dly [MD];
    coeff_t fin_u;
    coeff_t fin_v;

    // (a + b) mod q
    function automatic coeff_t mod_add(coeff_t a, coeff_t b);
        logic [`NTT_COEFF_W:0] s;
        s = {1'b0, a} + {1'b0, b};
        if (s >= {1'b0, `NTT_Q}) begin
            s = s - {1'b0, `NTT_Q};
        end
        return s[`NTT_COEFF_W-1:0];
    endfunction

    // (a - b) mod q, wraps back up on borrow
    function automatic coeff_t mod_sub(coeff_t a, coeff_t b);
        logic [`NTT_COEFF_W:0] d;
        d = {1'b0, a} - {1'b0, b};
        if (a < b) begin
            d = d + {1'b0, `NTT_Q};
        end
        return d[`NTT_COEFF_W-1:0];
    endfunction

    assign gs_mode  = (ctrl.mode == gs);
    assign pwm_mode = (ctrl.mode == pwm);
    assign pws_mode = (ctrl.mode == pws);

    // ------------------------------
    // multiplier operand select
    // ------------------------------
    // gs multiplies after the subtract, one cycle later than ct/pwm
    assign mul_a = gs_mode ? diff_q1 : (pwm_mode ? u_i : v_i);
    assign mul_b = gs_mode ? w_q1 : (pwm_mode ? v_i : w_i);

    // ct adds u after the multiply, pwm adds w or nothing
    assign addend = pwm_mode ? (ctrl.accumulate ? w_i : '0) : u_i;

    ntt_mod_mult u_mult (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (ctrl.zeroize),
        .a_i       (mul_a),
        .b_i       (mul_b),
        .p_o       (prod)
    );

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n || ctrl.zeroize) begin
            sum_q1  <= '0;
            diff_q1 <= '0;
            w_q1    <= '0;
            fin_u   <= '0;
            fin_v   <= '0;
            for (int i = 0; i < MD; i++) begin
                add_dly[i] <= '0;
                as_dly[i]  <= '0;
            end
        end else begin
            // add/sub stage, used by gs, pwa and pws
            sum_q1     <= mod_add(u_i, v_i);
            diff_q1    <= mod_sub(u_i, v_i);
            w_q1       <= w_i;
            // u or accumulator waits for the product
            add_dly[0] <= addend;
            // add/sub result waits for the gs product
            as_dly[0]  <= pws_mode ? diff_q1 : sum_q1;
            for (int i = 1; i < MD; i++) begin
                add_dly[i] <= add_dly[i-1];
                as_dly[i]  <= as_dly[i-1];
            end
            // ct/pwm closing add/sub, lands on cycle four
            fin_u <= mod_add(add_dly[MD-1], prod);
            fin_v <= mod_sub(add_dly[MD-1], prod);
        end
    end

    // gs results come straight from the delay line and the multiplier
    assign u_o  = gs_mode ? as_dly[MD-1] : fin_u;
    assign v_o  = gs_mode ? prod : fin_v;
    assign pw_o = pwm_mode ? fin_u : as_dly[MD-1];

endmodule

//--- hw/ntt_butterfly_2x2.sv
// ct/gs take eight cycles and pointwise four; w lanes 2,3 are the stage-2 twiddles in ct/gs
`timescale 1ns/1ps
`include "ntt_settings.svh"

module ntt_butterfly_2x2
    import ntt_params_pkg::*;
    import ntt_ops_pkg::*;
(
    input  logic        clk,
    input  logic        reset_n,
    ntt_ctrl_if.dp_mp   ctrl,
    input  coeff_quad_t u_i,
    input  coeff_quad_t v_i,
    input  coeff_quad_t w_i,
    output coeff_quad_t uv_o,
    output coeff_quad_t pwo_o
);

    localparam int BD = `NTT_BF_LATENCY;

    mode_class_t mcls;
    // operands into units 0..3
    coeff_t bf_u [4];
    coeff_t bf_v [4];
    coeff_t bf_w [4];
    // results out of units 0..3
    coeff_t st_u [4];
    coeff_t st_v [4];
    coeff_t st_pw [4];
    // twiddles held until stage 1 finishes
    coeff_t w2_dly [BD];
    coeff_t w3_dly [BD];

    assign mcls = classify(ctrl.mode);

    // ------------------------------
    // twiddle delay, lanes 2 and 3
    // ------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n || ctrl.zeroize) begin
            for (int i = 0; i < BD; i++) begin
                w2_dly[i] <= '0;
                w3_dly[i] <= '0;
            end
        end else begin
            w2_dly[0] <= w_i[2];
            w3_dly[0] <= w_i[3];
            for (int i = 1; i < BD; i++) begin
                w2_dly[i] <= w2_dly[i-1];
                w3_dly[i] <= w3_dly[i-1];
            end
        end
    end

    // ------------------------------
    // operand routing
    // ------------------------------
    always_comb begin
        // stage 1 always reads lanes 0 and 1
        for (int n = 0; n < 2; n++) begin
            bf_u[n] = u_i[n];
            bf_v[n] = v_i[n];
            bf_w[n] = w_i[n];
        end
        if (mcls.pw) begin
            // independent lanes
            for (int n = 2; n < 4; n++) begin
                bf_u[n] = u_i[n];
                bf_v[n] = v_i[n];
                bf_w[n] = w_i[n];
            end
        end else begin
            // cross the stage-1 outputs into stage 2
            bf_u[2] = st_u[0];
            bf_v[2] = st_u[1];
            bf_w[2] = w2_dly[BD-1];
            bf_u[3] = st_v[0];
            bf_v[3] = st_v[1];
            bf_w[3] = w3_dly[BD-1];
        end
    end

    // units 0,1 form stage 1, units 2,3 stage 2
    for (genvar n = 0; n < 4; n++) begin : g_bf
        ntt_butterfly u_bf (
            .clk     (clk),
            .reset_n (reset_n),
            .ctrl    (ctrl),
            .u_i     (bf_u[n]),
            .v_i     (bf_v[n]),
            .w_i     (bf_w[n]),
            .u_o     (st_u[n]),
            .v_o     (st_v[n]),
            .pw_o    (st_pw[n])
        );
        assign pwo_o[n] = st_pw[n];
    end

    // transform output order, stage-2 unit by unit
    assign uv_o[0] = st_u[2];
    assign uv_o[1] = st_v[2];
    assign uv_o[2] = st_u[3];
    assign uv_o[3] = st_v[3];

endmodule

//--- hw/ntt_ctrl_if.sv
// control only, no clock inside; mode must be held for a whole run by the driver
`timescale 1ns/1ps

interface ntt_ctrl_if
    import ntt_ops_pkg::*;
();

    // operation for the current run
    mode_t mode;
    // one input set per high cycle
    logic  enable;
    // pwm only, adds w to the product
    logic  accumulate;
    // synchronous clear of every stage
    logic  zeroize;

    // ready delay line
    modport ctrl_mp (
        input mode,
        input enable,
        input accumulate,
        input zeroize
    );

    // datapath units
    modport dp_mp (
        input mode,
        input accumulate,
        input zeroize
    );

endinterface

//--- hw/ntt_mod_mult.sv
// operands must be below q; the result is fully reduced and appears exactly three cycles later
`timescale 1ns/1ps
`include "ntt_settings.svh"

module ntt_mod_mult
    import ntt_params_pkg::*;
(
    input  logic   clk,
    input  logic   reset_n,
    input  logic   zeroize_i,
    input  coeff_t a_i,
    input  coeff_t b_i,
    output coeff_t p_o
);

    // barrett multiplier is one bit wider than a residue
    localparam int MW = `NTT_COEFF_W + 1;
    // x * m spans the shift plus the quotient
    localparam int XW = `NTT_BARRETT_K + MW;
    // quotient estimate times q
    localparam int TW = MW + `NTT_COEFF_W;

    prod_t          prod_q;
    logic [XW-1:0]  xm;
    logic [MW-1:0]  quot;
    logic [TW-1:0]  tq;
    logic [MW-1:0]  rem;
    logic [MW-1:0]  rem_q;
    logic [MW-1:0]  rem_red;
    coeff_t         p_q;

    // ------------------------------
    // barrett estimate
    // ------------------------------
    always_comb begin
        xm   = XW'(prod_q) * XW'(`NTT_BARRETT_M);
        // floor(x * m / 2^k), at most one below floor(x / q)
        quot = xm[`NTT_BARRETT_K +: MW];
        tq   = TW'(quot) * TW'(`NTT_Q);
        // true remainder is below 2q, so the low bits are exact
        rem  = prod_q[MW-1:0] - tq[MW-1:0];
    end

    // final conditional subtract
    assign rem_red = (rem_q >= MW'(`NTT_Q)) ? rem_q - MW'(`NTT_Q) : rem_q;

    // ------------------------------
    // three register stages
    // ------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            prod_q <= '0;
            rem_q  <= '0;
            p_q    <= '0;
        end else if (zeroize_i) begin
            prod_q <= '0;
            rem_q  <= '0;
            p_q    <= '0;
        end else begin
            // stage 1, raw product
            prod_q <= prod_t'(a_i) * prod_t'(b_i);
            // stage 2, remainder in [0, 2q)
            rem_q  <= rem;
            // stage 3, reduced
            p_q    <= rem_red[`NTT_COEFF_W-1:0];
        end
    end

    assign p_o = p_q;

endmodule

//--- hw/ntt_ops_pkg.sv
// mode encoding is fixed; idle must be driven whenever no run is in progress

package ntt_ops_pkg;

    // operation selected for a whole run
    typedef enum logic [2:0] {ct, gs, pwm, pwa, pws, idle} mode_t;

    // two-stage transform vs four independent lanes
    typedef struct packed {
        logic bf;
        logic pw;
    } mode_class_t;

    // idle belongs to neither class
    function automatic mode_class_t classify(mode_t m);
        mode_class_t c;
        c.bf = (m == ct) || (m == gs);
        c.pw = (m == pwm) || (m == pwa) || (m == pws);
        return c;
    endfunction

endpackage

//--- hw/ntt_params_pkg.sv
// word types only, every coefficient is assumed already reduced below q
`include "ntt_settings.svh"

package ntt_params_pkg;

    // ------------------------------
    // coefficient words
    // ------------------------------
    // one residue in [0, q)
    typedef logic [`NTT_COEFF_W-1:0] coeff_t;

    // full product of two residues, before reduction
    typedef logic [2*`NTT_COEFF_W-1:0] prod_t;

    // ------------------------------
    // lane bundles
    // ------------------------------
    // four coeff_t lanes, lane n at [n]
    // ct/gs use lanes 0,1 for stage 1 and w lanes 2,3 as stage-2 twiddles
    typedef logic [3:0][`NTT_COEFF_W-1:0] coeff_quad_t;

endpackage

//--- hw/ntt_ready_ctrl.sv
// assumes mode is held from first enable to last ready; enables seen in idle are dropped
`timescale 1ns/1ps
`include "ntt_settings.svh"

module ntt_ready_ctrl
    import ntt_ops_pkg::*;
(
    input  logic        clk,
    input  logic        reset_n,
    ntt_ctrl_if.ctrl_mp ctrl,
    output logic        ready_o
);

    // two butterfly stages deep
    localparam int DEPTH = 2 * `NTT_BF_LATENCY;

    mode_class_t      mcls;
    logic             en_in;
    logic [DEPTH-1:0] en_q;

    assign mcls = classify(ctrl.mode);

    // only a real operation starts an item
    assign en_in = ctrl.enable & (mcls.bf | mcls.pw);

    // ------------------------------
    // enable delay line
    // ------------------------------
    // accumulate does not lengthen pwm, every unit is four cycles
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            en_q <= '0;
        end else if (ctrl.zeroize) begin
            // anything in flight is forgotten
            en_q <= '0;
        end else begin
            en_q <= {en_q[DEPTH-2:0], en_in};
        end
    end

    // tap 8 for ct/gs, tap 4 for pointwise, nothing in idle
    always_comb begin
        if (mcls.bf) begin
            ready_o = en_q[DEPTH-1];
        end else if (mcls.pw) begin
            ready_o = en_q[`NTT_BF_LATENCY-1];
        end else begin
            ready_o = 1'b0;
        end
    end

endmodule

//--- hw/ntt_top.sv
// no back-pressure: outputs hold only while ready_o is high, and all inputs must be below q
`timescale 1ns/1ps

module ntt_top
    import ntt_params_pkg::*;
    import ntt_ops_pkg::*;
(
    input  logic        clk,
    input  logic        reset_n,
    input  logic        zeroize_i,
    input  logic        enable_i,
    input  logic        accumulate_i,
    input  mode_t       mode_i,
    input  coeff_quad_t u_i,
    input  coeff_quad_t v_i,
    input  coeff_quad_t w_i,
    output coeff_quad_t uv_o,
    output coeff_quad_t pwo_o,
    output logic        ready_o
);

    // ------------------------------
    // control bundle
    // ------------------------------
    ntt_ctrl_if ctrl_if ();

    assign ctrl_if.mode       = mode_i;
    assign ctrl_if.enable     = enable_i;
    assign ctrl_if.accumulate = accumulate_i;
    assign ctrl_if.zeroize    = zeroize_i;

    // ------------------------------
    // datapath
    // ------------------------------
    // four butterflies, chained for ct/gs or side by side for pointwise
    ntt_butterfly_2x2 u_bf2x2 (
        .clk     (clk),
        .reset_n (reset_n),
        .ctrl    (ctrl_if.dp_mp),
        .u_i     (u_i),
        .v_i     (v_i),
        .w_i     (w_i),
        .uv_o    (uv_o),
        .pwo_o   (pwo_o)
    );

    // ------------------------------
    // ready generation
    // ------------------------------
    // tracks the datapath depth per mode
    ntt_ready_ctrl u_ready (
        .clk     (clk),
        .reset_n (reset_n),
        .ctrl    (ctrl_if.ctrl_mp),
        .ready_o (ready_o)
    );

endmodule

//--- include/ntt_settings.svh
// fixed to ml-dsa q = 8380417 and 23-bit residues; the latencies assume the three-stage multiplier
`ifndef NTT_SETTINGS_SVH
`define NTT_SETTINGS_SVH

// ------------------------------
// modulus and word width
// ------------------------------
// q = 2^23 - 2^13 + 1
`define NTT_Q 23'd8380417
`define NTT_COEFF_W 23

// barrett reduction, m = floor(2^k / q), products below 2^46
`define NTT_BARRETT_K 46
`define NTT_BARRETT_M 24'd8396807

// ------------------------------
// pipeline depths in cycles
// ------------------------------
`define NTT_MULT_LATENCY 3
`define NTT_BF_LATENCY 4

`endif

//--- run_sim.sh
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f filelist.f --top-module ntt_tb \
    --Mdir obj_dir -o ntt_tb_sim
./obj_dir/ntt_tb_sim
